/* run_sim.sh */
#!/bin/sh
# Compile and run the stream fault detector testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module stream_fault_detector_tb \
    --Mdir "$build_dir" -f vlog.f
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

"./$build_dir/Vstream_fault_detector_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$log_file"; then
    exit 1
fi
exit 0

/* source/fast_fault_checker.sv */
////////////////////////////////////////
// Fast fault checker
// Trips a channel on any single sample
// outside the fast window
////////////////////////////////////////
`timescale 1ns/1ps

module fast_fault_checker (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  fault_detector_pkg::stream_sample_t         sample,
    input  fault_detector_pkg::window_t                window,
    output logic [fault_detector_pkg::n_channels-1:0]  trip
);

    logic [fault_detector_pkg::n_channels-1:0] hit;
    logic                                      miss;
    logic [fault_detector_pkg::n_channels-1:0] trip_next;

    // Channel decode, empty for idle cycles and foreign destinations
    assign hit = fault_detector_pkg::channel_hit(sample);

    // The comparison is shared, only the addressed channel can use it
    assign miss = fault_detector_pkg::outside_window(sample.data, window);

    // Replicate the miss over the one-hot channel select
    assign trip_next = hit & {fault_detector_pkg::n_channels{miss}};

    // Registered so the pulse appears one cycle after the sample
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            trip <= '0;
        end else begin
            trip <= trip_next;
        end
    end

endmodule

/* source/fault_config_regs.sv */
////////////////////////////////////////
// Fault detector register block
// Holds thresholds and trip duration, returns
// stored values and the live status word
////////////////////////////////////////
`timescale 1ns/1ps

module fault_config_regs (
    input  logic                          clock,
    input  logic                          rst_n,
    input  fault_detector_pkg::reg_req_t  reg_req,
    output fault_detector_pkg::reg_rsp_t  reg_rsp,
    input  logic                          fast_any,
    input  logic                          slow_any,
    output fault_detector_pkg::fault_cfg_t cfg
);

    fault_detector_pkg::reg_addr_e       addr;
    logic [fault_detector_pkg::data_bits-1:0] read_mux;
    logic [fault_detector_pkg::data_bits-1:0] status_word;

    // The raw address maps straight onto the register enum
    assign addr = fault_detector_pkg::reg_addr_e'(reg_req.addr);

    // Status carries the fast summary in bit 1 and the slow summary in bit 0
    assign status_word = {{(fault_detector_pkg::data_bits - 2){1'b0}}, fast_any, slow_any};

    // A write strobe updates cfg on the following edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cfg.slow.low  <= fault_detector_pkg::reset_low;
            cfg.slow.high <= fault_detector_pkg::reset_high;
            cfg.fast.low  <= fault_detector_pkg::reset_low;
            cfg.fast.high <= fault_detector_pkg::reset_high;
            cfg.duration  <= fault_detector_pkg::reset_duration;
        end else if (reg_req.wr) begin
            case (addr)
                fault_detector_pkg::slow_low: begin
                    cfg.slow.low <= reg_req.wdata;
                end
                fault_detector_pkg::slow_high: begin
                    cfg.slow.high <= reg_req.wdata;
                end
                fault_detector_pkg::slow_duration: begin
                    // Only the low byte of the written word is kept
                    cfg.duration <= reg_req.wdata[fault_detector_pkg::dur_bits-1:0];
                end
                fault_detector_pkg::fast_low: begin
                    cfg.fast.low <= reg_req.wdata;
                end
                fault_detector_pkg::fast_high: begin
                    cfg.fast.high <= reg_req.wdata;
                end
                default: begin
                    // Status is read only and 6 or 7 hold nothing
                end
            endcase
        end
    end

    // Read multiplexer over the register map
    always_comb begin
        case (addr)
            fault_detector_pkg::slow_low:      read_mux = cfg.slow.low;
            fault_detector_pkg::slow_high:     read_mux = cfg.slow.high;
            fault_detector_pkg::slow_duration: begin
                read_mux = {{(fault_detector_pkg::data_bits - fault_detector_pkg::dur_bits){1'b0}},
                            cfg.duration};
            end
            fault_detector_pkg::fast_low:      read_mux = cfg.fast.low;
            fault_detector_pkg::fast_high:     read_mux = cfg.fast.high;
            fault_detector_pkg::status:        read_mux = status_word;
            default:                           read_mux = '0;
        endcase
    end

    // The response follows the read request by one cycle and carries its data
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            reg_rsp.valid <= 1'b0;
            reg_rsp.rdata <= '0;
        end else begin
            reg_rsp.valid <= reg_req.rd;
            if (reg_req.rd) begin
                reg_rsp.rdata <= read_mux;
            end
        end
    end

endmodule

/* source/fault_detector_core.sv */
////////////////////////////////////////
// Fault detector core
// Runs fast and slow checkers on the stream and
// keeps sticky per-channel fault flags
////////////////////////////////////////
`timescale 1ns/1ps

module fault_detector_core (
    input  logic                                clock,
    input  logic                                rst_n,
    input  fault_detector_pkg::stream_sample_t  sample,
    input  fault_detector_pkg::fault_cfg_t      cfg,
    input  logic                                clear_fault,
    output logic                                fault,
    output logic                                fast_any,
    output logic                                slow_any
);

    logic [fault_detector_pkg::n_channels-1:0] fast_trip;
    logic [fault_detector_pkg::n_channels-1:0] slow_trip;
    logic [fault_detector_pkg::n_channels-1:0] fast_flags;
    logic [fault_detector_pkg::n_channels-1:0] slow_flags;

    // Both checkers look at the same beat in the same cycle
    fast_fault_checker fast_checker (
        .clock  (clock),
        .rst_n  (rst_n),
        .sample (sample),
        .window (cfg.fast),
        .trip   (fast_trip)
    );

    slow_fault_checker slow_checker (
        .clock    (clock),
        .rst_n    (rst_n),
        .sample   (sample),
        .window   (cfg.slow),
        .duration (cfg.duration),
        .trip     (slow_trip)
    );

    // Clear empties the flags first, a trip in the same cycle then sets them again
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fast_flags <= '0;
            slow_flags <= '0;
        end else begin
            fast_flags <= (clear_fault ? '0 : fast_flags) | fast_trip;
            slow_flags <= (clear_fault ? '0 : slow_flags) | slow_trip;
        end
    end

    // Summary outputs are plain reductions of the flags
    assign fast_any = |fast_flags;
    assign slow_any = |slow_flags;
    assign fault    = fast_any | slow_any;

endmodule

/* source/fault_detector_pkg.sv */
////////////////////////////////////////
// Fault detector shared definitions
// Sizes, bus and stream beats, the register map,
// reset values and the sample decode helpers
////////////////////////////////////////

package fault_detector_pkg;

    // Channel layout of the monitored stream
    localparam int n_channels    = 4;
    localparam int starting_dest = 0;
    localparam int chan_bits     = 2;

    // Field widths
    localparam int dest_bits     = 8;
    localparam int data_bits     = 32;
    localparam int dur_bits      = 8;
    localparam int reg_addr_bits = 3;

    // Reset values leave both windows fully open
    localparam logic signed [data_bits-1:0] reset_low  = {1'b1, {(data_bits-1){1'b0}}};
    localparam logic signed [data_bits-1:0] reset_high = {1'b0, {(data_bits-1){1'b1}}};
    localparam logic [dur_bits-1:0]         reset_duration = dur_bits'(1);

    typedef struct packed {
        logic                        valid;
        logic [dest_bits-1:0]        dest;
        logic signed [data_bits-1:0] data;
    } stream_sample_t;

    typedef struct packed {
        logic                     wr;
        logic                     rd;
        logic [reg_addr_bits-1:0] addr;
        logic [data_bits-1:0]     wdata;
    } reg_req_t;

    typedef struct packed {
        logic                 valid;
        logic [data_bits-1:0] rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic signed [data_bits-1:0] low;
        logic signed [data_bits-1:0] high;
    } window_t;

    typedef struct packed {
        window_t              fast;
        window_t              slow;
        logic [dur_bits-1:0]  duration;
    } fault_cfg_t;

    // Register map, addresses 6 and 7 are unused
    typedef enum logic [reg_addr_bits-1:0] {
        slow_low      = 3'd0,
        slow_high     = 3'd1,
        slow_duration = 3'd2,
        fast_low      = 3'd3,
        fast_high     = 3'd4,
        status        = 3'd5
    } reg_addr_e;

    // One-hot channel of a valid sample, all zero when dest is out of range
    function automatic logic [n_channels-1:0] channel_hit(input stream_sample_t s);
        logic [dest_bits:0]    offset;
        logic [n_channels-1:0] hit;
        // A dest below the first channel wraps into the top half and fails the range test
        offset = {1'b0, s.dest} - (dest_bits + 1)'(starting_dest);
        hit = '0;
        if (s.valid && (offset < (dest_bits + 1)'(n_channels))) begin
            hit[offset[chan_bits-1:0]] = 1'b1;
        end
        return hit;
    endfunction

    // Signed comparison against both edges of a window
    function automatic logic outside_window(input logic signed [data_bits-1:0] d,
                                            input window_t w);
        return (d < w.low) || (d > w.high);
    endfunction

endpackage

/* source/slow_fault_checker.sv */
////////////////////////////////////////
// Slow fault checker
// Counts consecutive out-of-window samples per
// channel and trips once the duration is reached
////////////////////////////////////////
`timescale 1ns/1ps

module slow_fault_checker (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  fault_detector_pkg::stream_sample_t         sample,
    input  fault_detector_pkg::window_t                window,
    input  logic [fault_detector_pkg::dur_bits-1:0]    duration,
    output logic [fault_detector_pkg::n_channels-1:0]  trip
);

    logic [fault_detector_pkg::n_channels-1:0] hit;
    logic                                      miss;
    logic [fault_detector_pkg::dur_bits-1:0]   limit;
    logic [fault_detector_pkg::dur_bits-1:0]   count      [fault_detector_pkg::n_channels];
    logic [fault_detector_pkg::dur_bits-1:0]   count_next [fault_detector_pkg::n_channels];
    logic [fault_detector_pkg::n_channels-1:0] trip_next;

    assign hit  = fault_detector_pkg::channel_hit(sample);
    assign miss = fault_detector_pkg::outside_window(sample.data, window);

    // A programmed duration of zero behaves like one
    assign limit = (duration == '0) ? fault_detector_pkg::dur_bits'(1) : duration;

    // Only the addressed channel moves, the others keep their count
    always_comb begin
        for (int i = 0; i < fault_detector_pkg::n_channels; i++) begin
            count_next[i] = count[i];
            trip_next[i]  = 1'b0;
            if (hit[i]) begin
                if (miss) begin
                    // Saturate at the counter maximum instead of wrapping
                    if (count[i] != '1) begin
                        count_next[i] = count[i] + 1'b1;
                    end
                    // Every miss at or past the limit gives another pulse
                    trip_next[i] = (count_next[i] >= limit);
                end else begin
                    // An in-window sample breaks the run
                    count_next[i] = '0;
                end
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < fault_detector_pkg::n_channels; i++) begin
                count[i] <= '0;
            end
            trip <= '0;
        end else begin
            for (int i = 0; i < fault_detector_pkg::n_channels; i++) begin
                count[i] <= count_next[i];
            end
            trip <= trip_next;
        end
    end

endmodule

/* source/stream_fault_detector.sv */
////////////////////////////////////////
// Stream fault detector top level
// Register block plus the detection core
////////////////////////////////////////
`timescale 1ns/1ps

module stream_fault_detector (
    input  logic                                clock,
    input  logic                                rst_n,
    input  fault_detector_pkg::stream_sample_t  sample,
    input  fault_detector_pkg::reg_req_t        reg_req,
    output fault_detector_pkg::reg_rsp_t        reg_rsp,
    input  logic                                clear_fault,
    output logic                                fault
);

    // Configuration toward the core
    fault_detector_pkg::fault_cfg_t cfg;

    // Summaries returned for the status word
    logic fast_any;
    logic slow_any;

    fault_config_regs regs (
        .clock    (clock),
        .rst_n    (rst_n),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp),
        .fast_any (fast_any),
        .slow_any (slow_any),
        .cfg      (cfg)
    );

    fault_detector_core core (
        .clock       (clock),
        .rst_n       (rst_n),
        .sample      (sample),
        .cfg         (cfg),
        .clear_fault (clear_fault),
        .fault       (fault),
        .fast_any    (fast_any),
        .slow_any    (slow_any)
    );

endmodule

/* testbench/stream_fault_detector_assertions.sv */
////////////////////////////////////////
// Fault detector core assertions
// Reset, trip pulse and sticky flag rules
////////////////////////////////////////
`timescale 1ns/1ps

module stream_fault_detector_assertions (
    input logic                                       clock,
    input logic                                       rst_n,
    input fault_detector_pkg::stream_sample_t         sample,
    input logic [fault_detector_pkg::n_channels-1:0]  fast_trip,
    input logic [fault_detector_pkg::n_channels-1:0]  slow_trip,
    input logic                                       clear_fault,
    input logic                                       fault
);

    // The summary output is held low while reset is asserted
    fault_low_in_reset: assert property (@(posedge clock) !rst_n |-> !fault)
        else $error("fault is high during reset");

    // A trip only repeats when another beat arrived right behind it
    fast_trip_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        (|fast_trip) && !sample.valid |=> !(|fast_trip))
        else $error("fast trip held without a new sample");

    slow_trip_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        (|slow_trip) && !sample.valid |=> !(|slow_trip))
        else $error("slow trip held without a new sample");

    // A trip sets its flag on the next edge even against a clear
    trip_raises_fault: assert property (@(posedge clock) disable iff (!rst_n)
        (|(fast_trip | slow_trip)) |=> fault)
        else $error("fault did not rise after a trip");

    // Clear with nothing pending leaves every flag empty
    clear_lowers_fault: assert property (@(posedge clock) disable iff (!rst_n)
        clear_fault && !(|fast_trip) && !(|slow_trip) |=> !fault)
        else $error("fault still high after a clear");

endmodule

bind fault_detector_core stream_fault_detector_assertions core_checks (
    .clock       (clock),
    .rst_n       (rst_n),
    .sample      (sample),
    .fast_trip   (fast_trip),
    .slow_trip   (slow_trip),
    .clear_fault (clear_fault),
    .fault       (fault)
);

/* testbench/stream_fault_detector_tb.sv */
////////////////////////////////////////
// Stream fault detector testbench
// Random stimulus checked every cycle
// against a cycle model of the detector
////////////////////////////////////////
`timescale 1ns/1ps

module stream_fault_detector_tb;

    // Cycle budgets of the five test phases, the timeout is derived from them
    localparam int reg_cycles    = 100;
    localparam int fast_cycles   = 420;
    localparam int slow_cycles   = 680;
    localparam int clear_cycles  = 410;
    localparam int stress_cycles = 2010;
    localparam int cycle_limit   = 2 * (reg_cycles + fast_cycles + slow_cycles
                                        + clear_cycles + stress_cycles) + 100;

    logic                               clock;
    logic                               rst_n;
    fault_detector_pkg::stream_sample_t sample;
    fault_detector_pkg::reg_req_t       reg_req;
    fault_detector_pkg::reg_rsp_t       reg_rsp;
    logic                               clear_fault;
    logic                               fault;

    integer seed;
    int     cycle_count;
    string  test_name;

    // Model state, one copy of everything the detector keeps
    fault_detector_pkg::fault_cfg_t               m_cfg;
    logic [fault_detector_pkg::dur_bits-1:0]      m_count [fault_detector_pkg::n_channels];
    logic [fault_detector_pkg::n_channels-1:0]    m_fast_trip;
    logic [fault_detector_pkg::n_channels-1:0]    m_slow_trip;
    logic [fault_detector_pkg::n_channels-1:0]    m_fast_flags;
    logic [fault_detector_pkg::n_channels-1:0]    m_slow_flags;
    logic                                         m_rsp_valid;
    logic [31:0]                                  m_rsp_data;
    logic                                         model_fault;

    stream_fault_detector DUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .sample      (sample),
        .reg_req     (reg_req),
        .reg_rsp     (reg_rsp),
        .clear_fault (clear_fault),
        .fault       (fault)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    assign model_fault = (|m_fast_flags) | (|m_slow_flags);

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Channel of a beat, or -1 when idle or outside the destination range
    function automatic int sample_channel(input fault_detector_pkg::stream_sample_t s);
        int d;
        d = int'(s.dest) - fault_detector_pkg::starting_dest;
        if (!s.valid || d < 0 || d >= fault_detector_pkg::n_channels) return -1;
        return d;
    endfunction

    // Readback as the register map defines it, status from the flags before the edge
    function automatic logic [31:0] model_read(input logic [2:0] addr);
        case (addr)
            3'd0:    return m_cfg.slow.low;
            3'd1:    return m_cfg.slow.high;
            3'd2:    return {24'd0, m_cfg.duration};
            3'd3:    return m_cfg.fast.low;
            3'd4:    return m_cfg.fast.high;
            3'd5:    return {30'd0, |m_fast_flags, |m_slow_flags};
            default: return 32'd0;
        endcase
    endfunction

    // Model step, the inputs seen here are the ones the DUT samples on this edge
    always @(posedge clock) begin : model_step
        int   ch;
        logic out_slow;
        logic [fault_detector_pkg::dur_bits-1:0] lim;
        if (!rst_n) begin
            m_cfg.slow.low  = fault_detector_pkg::reset_low;
            m_cfg.slow.high = fault_detector_pkg::reset_high;
            m_cfg.fast.low  = fault_detector_pkg::reset_low;
            m_cfg.fast.high = fault_detector_pkg::reset_high;
            m_cfg.duration  = fault_detector_pkg::reset_duration;
            for (int i = 0; i < fault_detector_pkg::n_channels; i++) m_count[i] = '0;
            {m_fast_trip, m_slow_trip, m_fast_flags, m_slow_flags} = '0;
            m_rsp_valid = 1'b0;
            m_rsp_data  = '0;
        end else begin
            m_rsp_valid = reg_req.rd;
            if (reg_req.rd) m_rsp_data = model_read(reg_req.addr);
            // Pending trips win over a clear in the same cycle
            if (clear_fault) {m_fast_flags, m_slow_flags} = '0;
            m_fast_flags = m_fast_flags | m_fast_trip;
            m_slow_flags = m_slow_flags | m_slow_trip;
            m_fast_trip = '0;
            m_slow_trip = '0;
            ch = sample_channel(sample);
            if (ch >= 0) begin
                m_fast_trip[ch] = (sample.data < m_cfg.fast.low) || (sample.data > m_cfg.fast.high);
                out_slow = (sample.data < m_cfg.slow.low) || (sample.data > m_cfg.slow.high);
                lim = (m_cfg.duration == 0) ? 8'd1 : m_cfg.duration;
                if (out_slow) begin
                    if (m_count[ch] != 8'hff) m_count[ch] = m_count[ch] + 8'd1;
                    m_slow_trip[ch] = (m_count[ch] >= lim);
                end else begin
                    m_count[ch] = '0;
                end
            end
            // Writes land last so the checkers above still used the old settings
            if (reg_req.wr) begin
                case (reg_req.addr)
                    3'd0:    m_cfg.slow.low  = reg_req.wdata;
                    3'd1:    m_cfg.slow.high = reg_req.wdata;
                    3'd2:    m_cfg.duration  = reg_req.wdata[7:0];
                    3'd3:    m_cfg.fast.low  = reg_req.wdata;
                    3'd4:    m_cfg.fast.high = reg_req.wdata;
                    default: ;
                endcase
            end
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clock) begin
        check_value("fault", 32'(model_fault), 32'(fault));
        check_value("rsp_valid", 32'(m_rsp_valid), 32'(reg_rsp.valid));
        if (m_rsp_valid) check_value("rsp_data", m_rsp_data, reg_rsp.rdata);
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic drive_cycle(input fault_detector_pkg::stream_sample_t s,
                               input fault_detector_pkg::reg_req_t r, input logic clr);
        @(posedge clock);
        sample      <= s;
        reg_req     <= r;
        clear_fault <= clr;
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        fault_detector_pkg::reg_req_t r;
        r = '0;
        r.wr    = 1'b1;
        r.addr  = addr;
        r.wdata = data;
        drive_cycle('0, r, 1'b0);
    endtask

    // The response is due exactly one cycle after the strobe
    task automatic read_check(input logic [2:0] addr, input logic [31:0] expected);
        fault_detector_pkg::reg_req_t r;
        r = '0;
        r.rd   = 1'b1;
        r.addr = addr;
        drive_cycle('0, r, 1'b0);
        drive_cycle('0, '0, 1'b0);
        @(negedge clock);
        check_value("read_valid", 32'd1, 32'(reg_rsp.valid));
        check_value("read_data", expected, reg_rsp.rdata);
    endtask

    // Window writes stay within a few thousand so trips happen often
    function automatic logic [31:0] write_value(input logic [2:0] addr);
        logic [31:0] r;
        r = $random(seed);
        case (addr)
            fault_detector_pkg::slow_low, fault_detector_pkg::fast_low: return 32'd0 - r % 2000;
            fault_detector_pkg::slow_high, fault_detector_pkg::fast_high: return r % 2000;
            fault_detector_pkg::slow_duration: return r % 8;
            default: return r;
        endcase
    endfunction

    task automatic random_cycle(input int valid_pct, input int clear_pct, input int rd_pct,
                                input int wr_pct, input int span);
        fault_detector_pkg::stream_sample_t s;
        fault_detector_pkg::reg_req_t       r;
        int                                 pick;
        s.valid = ({$random(seed)} % 100) < valid_pct;
        s.dest  = 8'({$random(seed)} % 6);
        s.data  = 32'({$random(seed)} % (2 * span + 1)) - 32'(span);
        r    = '0;
        pick = int'({$random(seed)} % 100);
        if (pick < rd_pct) begin
            r.rd   = 1'b1;
            r.addr = ($random(seed) & 1) ? 3'd5 : 3'({$random(seed)} % 8);
        end else if (pick < rd_pct + wr_pct) begin
            r.wr    = 1'b1;
            r.addr  = 3'({$random(seed)} % 8);
            r.wdata = write_value(r.addr);
        end
        drive_cycle(s, r, ({$random(seed)} % 100) < clear_pct);
    endtask

    initial begin : stimulus
        int                                 ch;
        int                                 len;
        int                                 mag;
        logic                               out;
        logic [2:0]                         a;
        logic [31:0]                        d;
        fault_detector_pkg::stream_sample_t s;
        seed        = 32'hda1455ea;
        cycle_count = 0;
        test_name   = "reset";
        rst_n       <= 1'b0;
        sample      <= '0;
        reg_req     <= '0;
        clear_fault <= 1'b0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        // Reset values, the status word and the empty addresses 6 and 7
        test_name = "register_access";
        for (int i = 0; i < 8; i++) read_check(3'(i), model_read(3'(i)));
        for (int i = 0; i < 20; i++) begin
            a = 3'({$random(seed)} % 5);
            d = $random(seed);
            write_reg(a, d);
            read_check(a, (a == 3'd2) ? {24'd0, d[7:0]} : d);
        end
        write_reg(3'd6, $random(seed));
        read_check(3'd6, 32'd0);

        test_name = "fast_fault";
        write_reg(3'd3, -32'sd1000);
        write_reg(3'd4, 32'sd1000);
        write_reg(3'd0, fault_detector_pkg::reset_low);
        write_reg(3'd1, fault_detector_pkg::reset_high);
        repeat (400) random_cycle(80, 3, 0, 0, 1500);

        // Runs on one channel with a few hops, idle beats must not count
        test_name = "slow_fault";
        write_reg(3'd3, fault_detector_pkg::reset_low);
        write_reg(3'd4, fault_detector_pkg::reset_high);
        write_reg(3'd0, -32'sd100);
        write_reg(3'd1, 32'sd100);
        repeat (60) begin
            write_reg(3'd2, {$random(seed)} % 7);
            ch  = int'({$random(seed)} % 4);
            out = $random(seed) & 1;
            len = 1 + int'({$random(seed)} % 8);
            repeat (len) begin
                if ({$random(seed)} % 4 == 0) ch = int'({$random(seed)} % 4);
                mag     = 101 + int'({$random(seed)} % 1000);
                s.valid = ({$random(seed)} % 5) != 0;
                s.dest  = 8'(ch + fault_detector_pkg::starting_dest);
                s.data  = out ? (($random(seed) & 1) ? -mag : mag)
                              : int'({$random(seed)} % 201) - 100;
                drive_cycle(s, '0, 1'b0);
            end
            drive_cycle('0, '0, 1'b1);
        end

        test_name = "clear_fault";
        write_reg(3'd3, -32'sd800);
        write_reg(3'd4, 32'sd800);
        repeat (400) random_cycle(70, 25, 15, 0, 1000);

        test_name = "mixed_stress";
        repeat (2000) random_cycle(95, 5, 10, 6, 2500);
        repeat (4) drive_cycle('0, '0, 1'b0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* vlog.f */
source/fault_detector_pkg.sv
source/fault_config_regs.sv
source/fast_fault_checker.sv
source/slow_fault_checker.sv
source/fault_detector_core.sv
source/stream_fault_detector.sv
testbench/stream_fault_detector_assertions.sv
testbench/stream_fault_detector_tb.sv
